//--- cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

	// instruction word and its fields
	typedef logic [31:0] instr_t;
	typedef logic [1:0] op_t;
	typedef logic [5:0] op3_t;
	typedef logic [3:0] cond_t;
	typedef logic [2:0] op2_t;

	// control word fields
	typedef logic [1:0] sel2_t;
	typedef logic [5:0] alu_op_t;

	// major opcode, bits 31:30
	localparam op_t OP_BRANCH = 2'b00;
	localparam op_t OP_CALL = 2'b01;
	localparam op_t OP_ALU = 2'b10;
	localparam op_t OP_MEM = 2'b11;

	// format 2 op2 field
	localparam op2_t OP2_BICC = 3'b010;
	localparam op2_t OP2_SETHI = 3'b100;

	localparam int IMM_BIT = 13;
	localparam int ANNUL_BIT = 29;
	localparam int ALU_CC_BIT = 4;

	// arithmetic op3, cc bit clear
	localparam op3_t ALU_OP3_ADD = 6'b000000;
	localparam op3_t ALU_OP3_ADDX = 6'b001000;
	localparam op3_t ALU_OP3_SUB = 6'b000100;
	localparam op3_t ALU_OP3_SUBX = 6'b001100;

	// logical op3, cc bit clear
	localparam op3_t ALU_OP3_AND = 6'b000001;
	localparam op3_t ALU_OP3_ANDN = 6'b000101;
	localparam op3_t ALU_OP3_OR = 6'b000010;
	localparam op3_t ALU_OP3_ORN = 6'b000110;
	localparam op3_t ALU_OP3_XOR = 6'b000011;
	localparam op3_t ALU_OP3_XNOR = 6'b000111;

	// shifts have no cc form
	localparam op3_t ALU_OP3_SLL = 6'b100101;
	localparam op3_t ALU_OP3_SRL = 6'b100110;
	localparam op3_t ALU_OP3_SRA = 6'b100111;

	// loads
	localparam op3_t LD_OP3_SW = 6'b001000;
	localparam op3_t LD_OP3_UB = 6'b000001;
	localparam op3_t LD_OP3_UH = 6'b000010;
	localparam op3_t LD_OP3_D = 6'b000011;
	localparam op3_t LD_OP3_SB = 6'b001001;
	localparam op3_t LD_OP3_SH = 6'b001010;
	localparam op3_t LD_OP3_STUB = 6'b001101;

	// stores
	localparam op3_t ST_OP3_W = 6'b000100;
	localparam op3_t ST_OP3_H = 6'b000110;
	localparam op3_t ST_OP3_D = 6'b000111;
	localparam op3_t ST_OP3_SWAP = 6'b001111;

	// alu overrides used with mop
	localparam alu_op_t ALU_OP_FWD_A = 6'b100000;
	localparam alu_op_t ALU_OP_FWD_B = 6'b100001;
	localparam alu_op_t ALU_OP_BR_TARGET = 6'b111111;

	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_SETHI,
		CLS_LOAD,
		CLS_STORE,
		CLS_CALL,
		CLS_BRANCH,
		CLS_ILLEGAL
	} instr_class_t;

	typedef enum logic [6:0] {
		RESET = 7'd0,
		FETCH_ADDR = 7'd1,
		FETCH_READ = 7'd2,
		FETCH_WAIT = 7'd3,
		DECODE = 7'd4,
		ALU_REG = 7'd10,
		ALU_IMM = 7'd11,
		ALU_REG_CC = 7'd12,
		ALU_IMM_CC = 7'd13,
		SETHI = 7'd14,
		LD_ADDR = 7'd20,
		LD_READ = 7'd21,
		LD_WAIT = 7'd22,
		LD_WRITE = 7'd23,
		ST_ADDR = 7'd25,
		ST_DATA = 7'd26,
		ST_WAIT = 7'd27,
		ST_DONE = 7'd28,
		LD_ADDR_IMM = 7'd30,
		ST_ADDR_IMM = 7'd35,
		CALL_LINK = 7'd40,
		CALL_JUMP = 7'd41,
		BR_TARGET = 7'd49,
		BR_PC = 7'd50,
		BR_SKIP = 7'd51,
		BR_ANNUL = 7'd52
	} state_t;

endpackage

`default_nettype wire

//--- decode_if.sv
`timescale 1ns/100ps
`default_nettype none

interface decode_if import cpu_ctrl_pkg::*; ();

	instr_class_t cls;
	logic use_imm;
	logic set_cc;
	logic annul;

	modport dec (
		output cls, use_imm, set_cc, annul
	);

	modport seq (
		input cls, use_imm, set_cc, annul
	);

endinterface

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module instr_decoder import cpu_ctrl_pkg::*; (
	input instr_t ir,
	decode_if.dec dec
);

	op_t op;
	op3_t op3;
	op3_t op3_base;
	op2_t op2;

	assign op = ir[31:30];
	assign op3 = ir[24:19];
	assign op2 = ir[24:22];

	// cc forms map onto the same base opcode
	always_comb begin
		op3_base = op3;
		op3_base[ALU_CC_BIT] = 1'b0;
	end

	assign dec.use_imm = ir[IMM_BIT];
	assign dec.set_cc = op3[ALU_CC_BIT];
	assign dec.annul = ir[ANNUL_BIT];

	always_comb begin
		dec.cls = CLS_ILLEGAL;
		case (op)
			OP_CALL: dec.cls = CLS_CALL;

			// sethi lives in format 2 next to the branches
			OP_BRANCH: begin
				case (op2)
					OP2_BICC: dec.cls = CLS_BRANCH;
					OP2_SETHI: dec.cls = CLS_SETHI;
					default: dec.cls = CLS_ILLEGAL;
				endcase
			end

			OP_ALU: begin
				case (op3)
					ALU_OP3_SLL, ALU_OP3_SRL, ALU_OP3_SRA: dec.cls = CLS_ALU;
					default: begin
						case (op3_base)
							ALU_OP3_ADD, ALU_OP3_ADDX,
							ALU_OP3_SUB, ALU_OP3_SUBX: dec.cls = CLS_ALU;
							ALU_OP3_AND, ALU_OP3_ANDN,
							ALU_OP3_OR, ALU_OP3_ORN,
							ALU_OP3_XOR, ALU_OP3_XNOR: dec.cls = CLS_ALU;
							default: dec.cls = CLS_ILLEGAL;
						endcase
					end
				endcase
			end

			OP_MEM: begin
				case (op3)
					LD_OP3_SW, LD_OP3_UB, LD_OP3_UH, LD_OP3_D,
					LD_OP3_SB, LD_OP3_SH, LD_OP3_STUB: dec.cls = CLS_LOAD;
					ST_OP3_W, ST_OP3_H, ST_OP3_D, ST_OP3_SWAP: dec.cls = CLS_STORE;
					default: dec.cls = CLS_ILLEGAL;
				endcase
			end
		endcase
	end

endmodule

`default_nettype wire

//--- sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module sequencer import cpu_ctrl_pkg::*; (
	input logic Clk,
	input logic Clr,
	decode_if.seq dec,
	input logic bcond,
	input logic moc,
	output state_t state
);

	state_t next_state;

	always_ff @(posedge Clk or negedge Clr) begin
		if (!Clr) begin
			state <= RESET;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		// wait states hold unless moc is seen
		next_state = state;
		case (state)
			RESET: next_state = FETCH_ADDR;
			FETCH_ADDR: next_state = FETCH_READ;
			FETCH_READ: next_state = FETCH_WAIT;
			FETCH_WAIT: begin
				if (moc) begin
					next_state = DECODE;
				end
			end

			DECODE: begin
				case (dec.cls)
					CLS_ALU: begin
						case ({dec.set_cc, dec.use_imm})
							2'b00: next_state = ALU_REG;
							2'b01: next_state = ALU_IMM;
							2'b10: next_state = ALU_REG_CC;
							default: next_state = ALU_IMM_CC;
						endcase
					end
					CLS_SETHI: next_state = SETHI;
					CLS_LOAD: next_state = dec.use_imm ? LD_ADDR_IMM : LD_ADDR;
					CLS_STORE: next_state = dec.use_imm ? ST_ADDR_IMM : ST_ADDR;
					CLS_CALL: next_state = CALL_LINK;
					CLS_BRANCH: begin
						if (bcond) begin
							next_state = BR_TARGET;
						end else begin
							next_state = dec.annul ? BR_ANNUL : BR_SKIP;
						end
					end
					default: next_state = FETCH_ADDR;
				endcase
			end

			ALU_REG, ALU_IMM, ALU_REG_CC, ALU_IMM_CC, SETHI: next_state = FETCH_ADDR;

			LD_ADDR, LD_ADDR_IMM: next_state = LD_READ;
			LD_READ: next_state = LD_WAIT;
			LD_WAIT: begin
				if (moc) begin
					next_state = LD_WRITE;
				end
			end
			LD_WRITE: next_state = FETCH_ADDR;

			ST_ADDR, ST_ADDR_IMM: next_state = ST_DATA;
			ST_DATA: next_state = ST_WAIT;
			ST_WAIT: begin
				if (moc) begin
					next_state = ST_DONE;
				end
			end
			ST_DONE: next_state = FETCH_ADDR;

			CALL_LINK: next_state = CALL_JUMP;
			CALL_JUMP: next_state = FETCH_ADDR;

			// target already sits in MAR
			BR_TARGET: next_state = BR_PC;
			BR_PC: next_state = FETCH_READ;
			BR_SKIP, BR_ANNUL: next_state = FETCH_ADDR;

			default: next_state = RESET;
		endcase
	end

	hold_while_waiting: assert property (@(posedge Clk) disable iff (!Clr)
		(state inside {FETCH_WAIT, LD_WAIT, ST_WAIT} && !moc) |=> $stable(state));

	legal_state: assert property (@(posedge Clk) disable iff (!Clr)
		state inside {RESET, FETCH_ADDR, FETCH_READ, FETCH_WAIT, DECODE,
			ALU_REG, ALU_IMM, ALU_REG_CC, ALU_IMM_CC, SETHI,
			LD_ADDR, LD_ADDR_IMM, LD_READ, LD_WAIT, LD_WRITE,
			ST_ADDR, ST_ADDR_IMM, ST_DATA, ST_WAIT, ST_DONE,
			CALL_LINK, CALL_JUMP, BR_TARGET, BR_PC, BR_SKIP, BR_ANNUL});

endmodule

`default_nettype wire

//--- control_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module control_encoder import cpu_ctrl_pkg::*; (
	input state_t state,
	output logic rf_load_en,
	output logic rf_clear_en,
	output logic ir_ld,
	output logic mar_ld,
	output logic mdr_ld,
	output logic pc_ld,
	output logic npc_ld,
	output logic fr_ld,
	output logic r_w,
	output logic mov,
	output logic mm,
	output logic mop,
	output logic msa,
	output sel2_t mem_type,
	output sel2_t mb,
	output sel2_t mnp,
	output sel2_t mp,
	output sel2_t msc,
	output alu_op_t alu_op
);

	// load enables
	assign rf_load_en = state inside {ALU_REG, ALU_IMM, ALU_REG_CC, ALU_IMM_CC,
		SETHI, LD_WRITE, CALL_LINK};
	assign rf_clear_en = state == RESET;
	assign ir_ld = state == FETCH_WAIT;
	assign mar_ld = state inside {FETCH_ADDR, LD_ADDR, LD_ADDR_IMM, ST_ADDR, ST_ADDR_IMM,
		BR_TARGET};
	assign mdr_ld = state inside {LD_WAIT, ST_DATA};
	assign pc_ld = state inside {RESET, FETCH_READ, CALL_JUMP, BR_SKIP, BR_ANNUL};
	assign npc_ld = state inside {RESET, FETCH_WAIT, CALL_JUMP, BR_PC, BR_SKIP, BR_ANNUL};
	assign fr_ld = state inside {ALU_REG_CC, ALU_IMM_CC};

	// memory strobes
	assign r_w = state inside {FETCH_READ, FETCH_WAIT, LD_ADDR, LD_ADDR_IMM, LD_READ, LD_WAIT,
		ST_ADDR, ST_ADDR_IMM};
	assign mov = state inside {FETCH_READ, FETCH_WAIT, LD_READ, LD_WAIT, ST_WAIT, ST_DONE};

	assign mm = state inside {ST_ADDR, ST_ADDR_IMM, ST_DATA};
	assign mop = state inside {FETCH_ADDR, SETHI, LD_ADDR, LD_ADDR_IMM, LD_WRITE,
		ST_ADDR, ST_ADDR_IMM, ST_DATA, CALL_LINK, BR_TARGET};
	assign msa = state == ST_DATA;

	always_comb begin
		// instruction fetch is a word access
		case (state)
			FETCH_READ, FETCH_WAIT: mem_type = 2'b10;
			default: mem_type = 2'b00;
		endcase

		case (state)
			ALU_IMM, ALU_IMM_CC, LD_ADDR_IMM, ST_ADDR_IMM: mb = 2'b01;
			FETCH_ADDR, SETHI, CALL_LINK, BR_TARGET: mb = 2'b10;
			LD_WRITE: mb = 2'b11;
			default: mb = 2'b00;
		endcase

		case (state)
			RESET, FETCH_READ, FETCH_WAIT, BR_SKIP: mnp = 2'b11;
			CALL_JUMP, BR_PC: mnp = 2'b10;
			BR_ANNUL: mnp = 2'b01;
			default: mnp = 2'b00;
		endcase

		case (state)
			FETCH_ADDR, FETCH_READ, CALL_JUMP, BR_TARGET, BR_PC, BR_SKIP: mp = 2'b11;
			BR_ANNUL: mp = 2'b10;
			default: mp = 2'b00;
		endcase

		// return address into the link register
		case (state)
			CALL_LINK: msc = 2'b01;
			default: msc = 2'b00;
		endcase

		case (state)
			FETCH_ADDR, LD_WRITE, CALL_LINK: alu_op = ALU_OP_FWD_B;
			ST_DATA: alu_op = ALU_OP_FWD_A;
			BR_TARGET: alu_op = ALU_OP_BR_TARGET;
			default: alu_op = 6'b000000;
		endcase
	end

	always_comb begin
		// instruction latched only while the fetch read is on the bus
		ir_only_in_fetch: assert (!ir_ld || (r_w && mov && mem_type == 2'b10));
		// both would drive the ALU result into two registers at once
		rf_mar_exclusive: assert (!(rf_load_en && mar_ld));
	end

endmodule

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import cpu_ctrl_pkg::*; (
	input logic Clk,
	input logic Clr,
	input instr_t ir,
	input logic bcond,
	input logic moc,
	output state_t state,
	output logic rf_load_en,
	output logic rf_clear_en,
	output logic ir_ld,
	output logic mar_ld,
	output logic mdr_ld,
	output logic pc_ld,
	output logic npc_ld,
	output logic fr_ld,
	output logic r_w,
	output logic mov,
	output logic mm,
	output logic mop,
	output logic msa,
	output sel2_t mem_type,
	output sel2_t mb,
	output sel2_t mnp,
	output sel2_t mp,
	output sel2_t msc,
	output alu_op_t alu_op
);

	decode_if dec_if ();

	instr_decoder decoder_i (
		.ir(ir),
		.dec(dec_if)
	);

	sequencer sequencer_i (
		.Clk(Clk),
		.Clr(Clr),
		.dec(dec_if),
		.bcond(bcond),
		.moc(moc),
		.state(state)
	);

	// control word follows the state register directly
	control_encoder encoder_i (.*);

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic Clk
);

	// 8 ns period
	initial begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

endmodule

`default_nettype wire

//--- control_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit_tb import cpu_ctrl_pkg::*; ();

	localparam int ROWS = 14;
	localparam instr_t CARE_F3 = 32'hC1F8_2000;
	localparam instr_t CARE_BR = 32'hE1C0_0000;
	localparam instr_t CARE_SETHI = 32'hC1C0_0000;
	localparam instr_t CARE_CALL = 32'hC000_0000;

	logic Clk;
	logic Clr;
	instr_t ir;
	logic bcond;
	logic moc;
	state_t state;
	logic rf_load_en, rf_clear_en, ir_ld, mar_ld, mdr_ld, pc_ld, npc_ld, fr_ld;
	logic r_w, mov, mm, mop, msa;
	sel2_t mem_type, mb, mnp, mp, msc;
	alu_op_t alu_op;

	// test table
	string row_name [ROWS];
	instr_t row_ir [ROWS];
	instr_t row_care [ROWS];
	logic row_bcond [ROWS];
	int row_wait [ROWS];
	state_t row_ret [ROWS];
	int row_len [ROWS];
	state_t row_path [ROWS][4];
	int n_rows = 0;
	int cycles = 0;
	int limit = 0;

	tb_clock_gen clock_i (.Clk(Clk));

	control_unit dut_i (.*);

	// rd and rs1 left zero
	function automatic instr_t format3_word(op_t op, op3_t op3, logic imm);
		return {op, 5'b00000, op3, 5'b00000, imm, 13'd0};
	endfunction

	function automatic instr_t format2_word(op2_t op2, logic annul);
		return {OP_BRANCH, annul, 4'b0000, op2, 22'd0};
	endfunction

	task automatic add_row(input string nm, input instr_t word, input instr_t care,
		input logic taken, input int waits, input state_t ret, input int len,
		input state_t s0, input state_t s1, input state_t s2, input state_t s3);
		row_name[n_rows] = nm;
		row_ir[n_rows] = word;
		row_care[n_rows] = care;
		row_bcond[n_rows] = taken;
		row_wait[n_rows] = waits;
		row_ret[n_rows] = ret;
		row_len[n_rows] = len;
		row_path[n_rows][0] = s0;
		row_path[n_rows][1] = s1;
		row_path[n_rows][2] = s2;
		row_path[n_rows][3] = s3;
		n_rows++;
	endtask

	task automatic stop_run();
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check_bit(input string nm, input string what, input logic exp,
		input logic act);
		assert (act === exp) else begin
			$display("ERROR %s %s: expected %b, actual %b", nm, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_sel(input string nm, input string what, input sel2_t exp,
		input sel2_t act);
		assert (act === exp) else begin
			$display("ERROR %s %s: expected %b, actual %b", nm, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_op(input string nm, input string what, input alu_op_t exp,
		input alu_op_t act);
		assert (act === exp) else begin
			$display("ERROR %s %s: expected %b, actual %b", nm, what, exp, act);
			stop_run();
		end
	endtask

	task automatic check_controls(input string nm, input state_t exp);
		check_bit(nm, "ir_ld", exp == FETCH_WAIT, ir_ld);
		check_bit(nm, "fr_ld", exp inside {ALU_REG_CC, ALU_IMM_CC}, fr_ld);
		// register file written only at write-back steps
		check_bit(nm, "rf_load_en", exp inside {ALU_REG, ALU_IMM, ALU_REG_CC, ALU_IMM_CC,
			SETHI, LD_WRITE, CALL_LINK}, rf_load_en);
		case (exp)
			RESET: begin
				check_bit(nm, "rf_clear_en", 1'b1, rf_clear_en);
				check_bit(nm, "pc_ld", 1'b1, pc_ld);
				check_bit(nm, "npc_ld", 1'b1, npc_ld);
				check_bit(nm, "mar_ld", 1'b0, mar_ld);
				check_bit(nm, "mdr_ld", 1'b0, mdr_ld);
			end
			FETCH_READ, FETCH_WAIT, LD_WAIT: begin
				check_bit(nm, "r_w", 1'b1, r_w);
				check_bit(nm, "mov", 1'b1, mov);
				if (exp != LD_WAIT) begin
					check_sel(nm, "mem_type", 2'b10, mem_type);
				end
			end
			// nothing is driven while the class is decided
			DECODE: begin
				check_bit(nm, "rf_clear_en", 1'b0, rf_clear_en);
				check_bit(nm, "mar_ld", 1'b0, mar_ld);
				check_bit(nm, "mdr_ld", 1'b0, mdr_ld);
				check_bit(nm, "pc_ld", 1'b0, pc_ld);
				check_bit(nm, "npc_ld", 1'b0, npc_ld);
				check_bit(nm, "r_w", 1'b0, r_w);
				check_bit(nm, "mov", 1'b0, mov);
				check_bit(nm, "mm", 1'b0, mm);
				check_bit(nm, "mop", 1'b0, mop);
				check_bit(nm, "msa", 1'b0, msa);
				check_sel(nm, "mem_type", 2'b00, mem_type);
				check_sel(nm, "mb", 2'b00, mb);
				check_sel(nm, "mnp", 2'b00, mnp);
				check_sel(nm, "mp", 2'b00, mp);
				check_sel(nm, "msc", 2'b00, msc);
				check_op(nm, "alu_op", 6'b000000, alu_op);
			end
			ALU_REG, ALU_REG_CC: check_sel(nm, "mb", 2'b00, mb);
			ALU_IMM, ALU_IMM_CC: check_sel(nm, "mb", 2'b01, mb);
			LD_ADDR: check_bit(nm, "mar_ld", 1'b1, mar_ld);
			LD_ADDR_IMM, ST_ADDR_IMM: begin
				check_bit(nm, "mar_ld", 1'b1, mar_ld);
				check_sel(nm, "mb", 2'b01, mb);
			end
			ST_ADDR: begin
				check_bit(nm, "mar_ld", 1'b1, mar_ld);
				check_bit(nm, "mm", 1'b1, mm);
			end
			ST_DATA: begin
				check_bit(nm, "mm", 1'b1, mm);
				check_bit(nm, "msa", 1'b1, msa);
			end
			// store writes memory
			ST_WAIT: begin
				check_bit(nm, "r_w", 1'b0, r_w);
				check_bit(nm, "mov", 1'b1, mov);
			end
			CALL_LINK: check_sel(nm, "msc", 2'b01, msc);
			CALL_JUMP: begin
				check_bit(nm, "pc_ld", 1'b1, pc_ld);
				check_bit(nm, "npc_ld", 1'b1, npc_ld);
			end
			BR_TARGET: begin
				check_bit(nm, "mar_ld", 1'b1, mar_ld);
				check_bit(nm, "mop", 1'b1, mop);
				check_op(nm, "alu_op", ALU_OP_BR_TARGET, alu_op);
			end
			BR_SKIP: begin
				check_sel(nm, "mp", 2'b11, mp);
				check_sel(nm, "mnp", 2'b11, mnp);
			end
			BR_ANNUL: begin
				check_sel(nm, "mp", 2'b10, mp);
				check_sel(nm, "mnp", 2'b01, mnp);
			end
			default: ;
		endcase
	endtask

	task automatic check_state(input string nm, input state_t exp);
		assert (state === exp) else begin
			$display("ERROR %s state: expected %s, actual %s", nm, exp.name(), state.name());
			stop_run();
		end
		check_controls(nm, exp);
	endtask

	task automatic next_cycle();
		@(posedge Clk);
		#1;
	endtask

	// wait states see moc low for the row's count, then high
	task automatic visit(input string nm, input state_t exp, input int waits);
		int k;
		check_state(nm, exp);
		if (exp inside {FETCH_WAIT, LD_WAIT, ST_WAIT}) begin
			for (k = 0; k < waits; k++) begin
				moc = 1'b0;
				next_cycle();
				check_state(nm, exp);
			end
		end
		moc = 1'b1;
		next_cycle();
	endtask

	always @(posedge Clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			stop_run();
		end
	end

	initial begin
		int r;
		int k;
		state_t resume;
		Clr = 1'b0;
		ir = '0;
		bcond = 1'b0;
		moc = 1'b1;
		void'($urandom(32'h6db2));

		add_row("add_reg", format3_word(OP_ALU, ALU_OP3_ADD, 1'b0), CARE_F3, 1'b0, 0,
			FETCH_ADDR, 1, ALU_REG, RESET, RESET, RESET);
		add_row("sll_imm", format3_word(OP_ALU, ALU_OP3_SLL, 1'b1), CARE_F3, 1'b0, 1,
			FETCH_ADDR, 1, ALU_IMM, RESET, RESET, RESET);
		add_row("subcc_reg", format3_word(OP_ALU, ALU_OP3_SUB | 6'b010000, 1'b0), CARE_F3,
			1'b0, 2, FETCH_ADDR, 1, ALU_REG_CC, RESET, RESET, RESET);
		add_row("andcc_imm", format3_word(OP_ALU, ALU_OP3_AND | 6'b010000, 1'b1), CARE_F3,
			1'b0, 0, FETCH_ADDR, 1, ALU_IMM_CC, RESET, RESET, RESET);
		add_row("sethi", format2_word(OP2_SETHI, 1'b0), CARE_SETHI, 1'b0, 1,
			FETCH_ADDR, 1, SETHI, RESET, RESET, RESET);
		add_row("call", {OP_CALL, 30'd0}, CARE_CALL, 1'b0, 0,
			FETCH_ADDR, 2, CALL_LINK, CALL_JUMP, RESET, RESET);
		add_row("illegal", format3_word(OP_ALU, 6'b111111, 1'b0), CARE_F3, 1'b0, 3,
			FETCH_ADDR, 0, RESET, RESET, RESET, RESET);
		add_row("ld_reg", format3_word(OP_MEM, LD_OP3_SW, 1'b0), CARE_F3, 1'b0, 2,
			FETCH_ADDR, 4, LD_ADDR, LD_READ, LD_WAIT, LD_WRITE);
		add_row("ldub_imm", format3_word(OP_MEM, LD_OP3_UB, 1'b1), CARE_F3, 1'b0, 0,
			FETCH_ADDR, 4, LD_ADDR_IMM, LD_READ, LD_WAIT, LD_WRITE);
		add_row("st_reg", format3_word(OP_MEM, ST_OP3_W, 1'b0), CARE_F3, 1'b0, 3,
			FETCH_ADDR, 4, ST_ADDR, ST_DATA, ST_WAIT, ST_DONE);
		add_row("sth_imm", format3_word(OP_MEM, ST_OP3_H, 1'b1), CARE_F3, 1'b0, 1,
			FETCH_ADDR, 4, ST_ADDR_IMM, ST_DATA, ST_WAIT, ST_DONE);
		add_row("br_taken", format2_word(OP2_BICC, 1'b1), CARE_BR, 1'b1, 1,
			FETCH_READ, 2, BR_TARGET, BR_PC, RESET, RESET);
		add_row("br_skip", format2_word(OP2_BICC, 1'b0), CARE_BR, 1'b0, 0,
			FETCH_ADDR, 1, BR_SKIP, RESET, RESET, RESET);
		add_row("br_annul", format2_word(OP2_BICC, 1'b1), CARE_BR, 1'b0, 2,
			FETCH_ADDR, 1, BR_ANNUL, RESET, RESET, RESET);

		// reset and margin, then fetch, decode, path and both waits per row
		limit = 24;
		for (r = 0; r < n_rows; r++) begin
			limit += 5 + row_len[r] + 2 * row_wait[r];
		end

		repeat (8) @(posedge Clk);
		#1;
		Clr = 1'b1;
		visit("reset", RESET, 0);
		resume = FETCH_ADDR;

		for (r = 0; r < n_rows; r++) begin
			// random bits in the fields the decoder ignores
			ir = (row_ir[r] & row_care[r]) | ($urandom() & ~row_care[r]);
			bcond = row_bcond[r];
			if (resume == FETCH_ADDR) begin
				visit(row_name[r], FETCH_ADDR, 0);
			end
			visit(row_name[r], FETCH_READ, 0);
			visit(row_name[r], FETCH_WAIT, row_wait[r]);
			visit(row_name[r], DECODE, 0);
			for (k = 0; k < row_len[r]; k++) begin
				visit(row_name[r], row_path[r][k], row_wait[r]);
			end
			check_state(row_name[r], row_ret[r]);
			resume = row_ret[r];
		end

		$display("NO ERRORS");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
cpu_ctrl_pkg.sv
decode_if.sv
instr_decoder.sv
sequencer.sv
control_encoder.sv
control_unit.sv
tb_clock_gen.sv
control_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, then pass only if the testbench printed its pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module control_unit_tb \
	-f build.f -o control_unit_sim || exit 1
out=$(./obj_dir/control_unit_sim 2>&1)
echo "$out"
echo "$out" | grep -q "NO ERRORS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
